//--- src/adc_capture_macros.svh
`ifndef ADC_CAPTURE_MACROS_SVH
`define ADC_CAPTURE_MACROS_SVH

// adc front end
`define ADC_LANES 8
`define SAMPLE_BITS 12

// raw lane slot and mean sum width
`define LANE_BITS 16

// sample memory
`define WORD_BITS 128
`define ADDR_BITS 15

// decimation divisor, group is divisor+1 frames
`define DIV_BITS 4

`endif

//--- src/adc_sample_pkg.sv
`default_nettype none

`include "adc_capture_macros.svh"

package adc_sample_pkg;

	typedef logic [`SAMPLE_BITS-1:0] sample_t; // one adc conversion

	typedef logic [`LANE_BITS-1:0] lane_sum_t; // zero-extended sample or group sum

	// one parallel frame from the adc
	typedef struct packed {
		logic valid;
		sample_t [`ADC_LANES-1:0] samples;
	} adc_frame_t;

	// group result of all lanes
	typedef struct packed {
		logic valid;
		lane_sum_t [`ADC_LANES-1:0] sums;
	} lane_frame_t;

endpackage

`default_nettype wire

//--- src/capture_ctrl_pkg.sv
`default_nettype none

`include "adc_capture_macros.svh"

package capture_ctrl_pkg;

	// held stable by software while busy
	typedef struct packed {
		logic [`ADDR_BITS-1:0] rec_length; // words per record
		logic [`DIV_BITS-1:0] divisor;
		logic mean_mode; // sum groups instead of keeping the last frame
		logic pack_mode; // 12 bit stream instead of 16 bit slots
	} capture_cfg_t;

	typedef enum logic [1:0] {
		idle = 2'd0,
		run = 2'd1,
		done = 2'd2
	} cap_state_t;

	// sample memory write port
	typedef struct packed {
		logic en;
		logic [`ADDR_BITS-1:0] addr;
		logic [`WORD_BITS-1:0] data;
	} mem_write_t;

	// per-frame strobes broadcast to every lane
	typedef struct packed {
		logic take; // a sample is present
		logic first; // opens a group
		logic emit; // closes a group
	} lane_ctl_t;

endpackage

`default_nettype wire

//--- src/lane_decimator.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_capture_macros.svh"

module lane_decimator (
	input wire adc_clkinp,
	input wire rst,
	input wire capture_ctrl_pkg::lane_ctl_t lane_ctl,
	input wire adc_sample_pkg::sample_t sample,
	input wire mean_mode,
	output adc_sample_pkg::lane_sum_t lane_out,
	output logic lane_valid
);

	adc_sample_pkg::lane_sum_t sample_ext;
	adc_sample_pkg::lane_sum_t acc; // running sum of the open group

	assign sample_ext = {{(`LANE_BITS-`SAMPLE_BITS){1'b0}}, sample};

	// wraps at 16 bits
	always_ff @(posedge adc_clkinp)
	begin
		if (rst)
			acc <= '0;
		else if (lane_ctl.take)
			acc <= lane_ctl.first ? sample_ext : acc + sample_ext;
	end

	// result includes the sample that closes the group
	always_comb
	begin
		if (!mean_mode || lane_ctl.first)
			lane_out = sample_ext; // decimate keeps the latest
		else
			lane_out = acc + sample_ext;
	end

	assign lane_valid = lane_ctl.take && lane_ctl.emit;

endmodule

`default_nettype wire

//--- src/capture_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_capture_macros.svh"

module capture_sequencer (
	input wire adc_clkinp,
	input wire rst,
	input wire adc_sample_pkg::adc_frame_t frame,
	input wire [`DIV_BITS-1:0] divisor,
	input wire trig,
	input wire clear,
	input wire record_end,
	output capture_ctrl_pkg::lane_ctl_t lane_ctl,
	output adc_sample_pkg::sample_t [`ADC_LANES-1:0] samples,
	output logic busy,
	output logic done
);

	capture_ctrl_pkg::cap_state_t state;
	logic [`DIV_BITS-1:0] grp_cnt; // position inside the current group
	logic frame_take;
	logic grp_first;
	logic grp_last;

	// only frames seen while running count
	assign frame_take = frame.valid && (state == capture_ctrl_pkg::run);
	assign grp_first = (grp_cnt == '0);
	assign grp_last = (grp_cnt == divisor);

	always_ff @(posedge adc_clkinp)
	begin
		if (rst)
		begin
			state <= capture_ctrl_pkg::idle;
			grp_cnt <= '0;
		end
		else if (clear)
		begin
			state <= capture_ctrl_pkg::idle;
			grp_cnt <= '0;
		end
		else
		begin
			case (state)
				capture_ctrl_pkg::idle:
				begin
					if (trig)
					begin
						state <= capture_ctrl_pkg::run;
						grp_cnt <= '0; // first valid frame opens a group
					end
				end
				capture_ctrl_pkg::run:
				begin
					if (record_end)
						state <= capture_ctrl_pkg::done;
					if (frame.valid)
						grp_cnt <= grp_last ? '0 : grp_cnt + 1'b1;
				end
				default: ; // done waits for clear
			endcase
		end
	end

	// strobes ride one cycle behind the frame, next to the samples
	always_ff @(posedge adc_clkinp)
	begin
		if (rst)
		begin
			lane_ctl <= '0;
		end
		else
		begin
			lane_ctl.take <= frame_take;
			lane_ctl.first <= frame_take && grp_first;
			lane_ctl.emit <= frame_take && grp_last;
		end
	end

	always_ff @(posedge adc_clkinp)
	begin
		samples <= frame.samples;
	end

	assign busy = (state == capture_ctrl_pkg::run);
	assign done = (state == capture_ctrl_pkg::done);

endmodule

`default_nettype wire

//--- src/word_packer.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_capture_macros.svh"

module word_packer (
	input wire adc_clkinp,
	input wire rst,
	input wire adc_sample_pkg::lane_frame_t lanes,
	input wire pack_mode,
	input wire [`ADDR_BITS-1:0] rec_length,
	input wire busy,
	output capture_ctrl_pkg::mem_write_t wr,
	output logic record_end
);

	localparam int FRAME_BITS = `ADC_LANES * `SAMPLE_BITS; // 96
	localparam int TAIL_BITS = `WORD_BITS - FRAME_BITS; // 32, spill per word

	logic [FRAME_BITS-1:0] pk_frame; // lanes as a 12 bit stream
	logic [`WORD_BITS-1:0] raw_word;
	logic [FRAME_BITS-1:0] hold; // stream bits not yet written, low aligned
	logic [1:0] set_cnt; // frame index in a set of four
	logic [`ADDR_BITS-1:0] addr_cnt;
	logic [`ADDR_BITS-1:0] addr_next;
	logic rec_full; // record written, ignore late frames
	logic wr_take;
	logic wr_fire;
	logic wr_en;
	logic [`ADDR_BITS-1:0] wr_addr;
	logic [`WORD_BITS-1:0] wr_data;

	always_comb
	begin
		for (int i = 0; i < `ADC_LANES; i++)
		begin
			pk_frame[i*`SAMPLE_BITS +: `SAMPLE_BITS] = lanes.sums[i][`SAMPLE_BITS-1:0];
			raw_word[i*`LANE_BITS +: `LANE_BITS] = lanes.sums[i];
		end
	end

	assign addr_next = addr_cnt + 1'b1;
	assign wr_take = lanes.valid && !rec_full;
	assign wr_fire = wr_take && (!pack_mode || set_cnt != 2'd0); // first of a set only fills

	always_ff @(posedge adc_clkinp)
	begin
		if (rst || !busy)
		begin
			wr_en <= 1'b0;
			record_end <= 1'b0;
			addr_cnt <= '0;
			set_cnt <= '0;
			rec_full <= 1'b0;
		end
		else
		begin
			wr_en <= wr_fire;
			record_end <= 1'b0;
			if (wr_take)
				set_cnt <= pack_mode ? set_cnt + 1'b1 : 2'd0;
			if (wr_fire)
			begin
				addr_cnt <= addr_next;
				if (addr_next == rec_length)
				begin
					record_end <= 1'b1; // same cycle as the last write
					rec_full <= 1'b1;
				end
			end
		end
	end

	// word j is stream bits 128j..128j+127
	always_ff @(posedge adc_clkinp)
	begin
		if (wr_take)
		begin
			wr_addr <= addr_cnt;
			if (!pack_mode)
			begin
				wr_data <= raw_word;
			end
			else
			begin
				case (set_cnt)
					2'd0: hold <= pk_frame;
					2'd1:
					begin
						wr_data <= {pk_frame[TAIL_BITS-1:0], hold};
						hold <= {{TAIL_BITS{1'b0}}, pk_frame[FRAME_BITS-1:TAIL_BITS]};
					end
					2'd2:
					begin
						wr_data <= {pk_frame[2*TAIL_BITS-1:0], hold[FRAME_BITS-TAIL_BITS-1:0]};
						hold <= {{2*TAIL_BITS{1'b0}}, pk_frame[FRAME_BITS-1:2*TAIL_BITS]};
					end
					default: wr_data <= {pk_frame, hold[TAIL_BITS-1:0]};
				endcase
			end
		end
	end

	assign wr = '{en: wr_en, addr: wr_addr, data: wr_data};

endmodule

`default_nettype wire

//--- src/adc_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_capture_macros.svh"

module adc_capture_top (
	input wire adc_clkinp,
	input wire rst,
	input wire adc_sample_pkg::adc_frame_t frame,
	input wire capture_ctrl_pkg::capture_cfg_t cfg,
	input wire trig,
	input wire clear,
	output capture_ctrl_pkg::mem_write_t wr,
	output logic busy,
	output logic done
);

	capture_ctrl_pkg::lane_ctl_t lane_ctl;
	adc_sample_pkg::sample_t [`ADC_LANES-1:0] samples;
	wire adc_sample_pkg::lane_frame_t lanes;
	wire [`ADC_LANES-1:0] lane_valid;
	logic record_end;

	capture_sequencer i_capture_sequencer (
		.adc_clkinp (adc_clkinp),
		.rst        (rst),
		.frame      (frame),
		.divisor    (cfg.divisor),
		.trig       (trig),
		.clear      (clear),
		.record_end (record_end),
		.lane_ctl   (lane_ctl),
		.samples    (samples),
		.busy       (busy),
		.done       (done)
	);

	// all lanes see the same strobes
	for (genvar i = 0; i < `ADC_LANES; i++)
	begin : g_lane
		lane_decimator i_lane_decimator (
			.adc_clkinp (adc_clkinp),
			.rst        (rst),
			.lane_ctl   (lane_ctl),
			.sample     (samples[i]),
			.mean_mode  (cfg.mean_mode),
			.lane_out   (lanes.sums[i]),
			.lane_valid (lane_valid[i])
		);
	end

	assign lanes.valid = &lane_valid; // lanes run in lockstep

	word_packer i_word_packer (
		.adc_clkinp (adc_clkinp),
		.rst        (rst),
		.lanes      (lanes),
		.pack_mode  (cfg.pack_mode),
		.rec_length (cfg.rec_length),
		.busy       (busy),
		.wr         (wr),
		.record_end (record_end)
	);

endmodule

`default_nettype wire

//--- test/capture_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_capture_macros.svh"

module capture_chk (
	input wire adc_clkinp,
	input wire rst,
	input wire capture_ctrl_pkg::mem_write_t wr,
	input wire busy,
	input wire done
);

	logic [`ADDR_BITS-1:0] last_addr;
	logic wrote; // a write was seen in this record
	int fail_cnt = 0;

	always_ff @(posedge adc_clkinp)
	begin
		if (rst || !busy)
			wrote <= 1'b0;
		else if (wr.en)
		begin
			wrote <= 1'b1;
			last_addr <= wr.addr;
		end
	end

	a_wr_busy: assert property (@(posedge adc_clkinp) disable iff (rst) wr.en |-> busy)
	else
	begin
		$error("memory write while the engine is not busy");
		fail_cnt++;
	end

	// busy hands over to done right after the last word
	a_done_entry: assert property (@(posedge adc_clkinp) disable iff (rst)
		$rose(done) |-> ($fell(busy) && $past(wr.en)))
	else
	begin
		$error("done rose without busy falling right after the last write");
		fail_cnt++;
	end

	a_addr_step: assert property (@(posedge adc_clkinp) disable iff (rst)
		(wr.en && wrote) |-> (wr.addr == last_addr + 1'b1))
	else
	begin
		$error("write address did not step by one");
		fail_cnt++;
	end

	a_rst_clean: assert property (@(posedge adc_clkinp) rst |=> (!busy && !done && !wr.en))
	else
	begin
		$error("flags or write enable high after reset");
		fail_cnt++;
	end

endmodule

bind adc_capture_top capture_chk i_capture_chk (
	.adc_clkinp (adc_clkinp),
	.rst        (rst),
	.wr         (wr),
	.busy       (busy),
	.done       (done)
);

`default_nettype wire

//--- test/capture_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_capture_macros.svh"

module capture_scoreboard (
	input wire adc_clkinp,
	input wire rst,
	input wire capture_ctrl_pkg::mem_write_t wr,
	input wire done
);

	localparam int DEPTH = 64;

	logic [`ADDR_BITS-1:0] exp_addr [DEPTH];
	logic [`WORD_BITS-1:0] exp_data [DEPTH];
	int head = 0;
	int tail = 0; // words queued but not yet seen
	int err_cnt = 0;
	logic done_q = 1'b0;

	// queued ahead of the frames that produce the word
	task automatic expect_word(input logic [`ADDR_BITS-1:0] addr,
		input logic [`WORD_BITS-1:0] data);
		exp_addr[tail % DEPTH] = addr;
		exp_data[tail % DEPTH] = data;
		tail++;
	endtask

	always @(negedge adc_clkinp)
	begin
		if (!rst && wr.en)
		begin
			if (head == tail)
			begin
				$display("write to address %h while no word was expected", wr.addr);
				err_cnt++;
			end
			else
			begin
				if (wr.addr !== exp_addr[head % DEPTH])
				begin
					$display("Mismatch wr.addr: got %h, expected %h", wr.addr,
						exp_addr[head % DEPTH]);
					err_cnt++;
				end
				if (wr.data !== exp_data[head % DEPTH])
				begin
					$display("Mismatch wr.data: got %h, expected %h", wr.data,
						exp_data[head % DEPTH]);
					err_cnt++;
				end
				head++;
			end
		end
		// last write lands a cycle before done
		if (!rst && done && !done_q && head != tail)
		begin
			$display("record ended with %0d expected words not written", tail - head);
			err_cnt++;
			head = tail;
		end
		done_q = done;
	end

endmodule

`default_nettype wire

//--- test/capture_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_capture_macros.svh"

module capture_tb;

	localparam int WAIT_LIMIT = 500; // cycles per wait
	localparam int FRAME_BITS = `ADC_LANES * `SAMPLE_BITS;

	logic adc_clkinp;
	logic rst;
	adc_sample_pkg::adc_frame_t frame;
	capture_ctrl_pkg::capture_cfg_t cfg;
	logic trig;
	logic clear;
	capture_ctrl_pkg::mem_write_t wr;
	logic busy;
	logic done;
	integer seed;
	int tb_errors;
	logic hung; // a wait ran out, stop reading cases

	adc_capture_top i_adc_capture_top (
		.adc_clkinp (adc_clkinp),
		.rst        (rst),
		.frame      (frame),
		.cfg        (cfg),
		.trig       (trig),
		.clear      (clear),
		.wr         (wr),
		.busy       (busy),
		.done       (done)
	);

	capture_scoreboard i_capture_scoreboard (
		.adc_clkinp (adc_clkinp),
		.rst        (rst),
		.wr         (wr),
		.done       (done)
	);

	always #20 adc_clkinp = ~adc_clkinp;

	// polled on the falling edge where the flags are settled
	task automatic wait_flags(input logic want_busy, input logic want_done, input string what);
		int cnt = 0;
		while (!hung && (busy !== want_busy || done !== want_done))
		begin
			@(negedge adc_clkinp);
			cnt++;
			if (cnt > WAIT_LIMIT)
			begin
				$display("timeout while waiting for %s", what);
				tb_errors++;
				hung = 1'b1;
			end
		end
	endtask

	task automatic send_frame(input logic [FRAME_BITS-1:0] samples);
		int gap;
		gap = $unsigned($random(seed)) % 3;
		frame.valid = 1'b1;
		frame.samples = samples;
		@(negedge adc_clkinp);
		frame.valid = 1'b0;
		repeat (gap) @(negedge adc_clkinp);
	endtask

	task automatic close_record();
		wait_flags(1'b0, 1'b1, "done at the end of the record");
		repeat (4) send_frame({`ADC_LANES{12'h5a5}}); // late frames, no write allowed
		if (busy || !done)
		begin
			$display("done did not hold while frames kept arriving");
			tb_errors++;
		end
		clear = 1'b1;
		@(negedge adc_clkinp);
		clear = 1'b0;
		wait_flags(1'b0, 1'b0, "idle after clear");
	endtask

	initial
	begin : main
		integer fd;
		string line;
		byte tag;
		logic [`WORD_BITS-1:0] v0, v1, v2, v3;
		int n;
		adc_clkinp = 1'b0;
		rst = 1'b1;
		frame = '0;
		cfg = '0;
		trig = 1'b0;
		clear = 1'b0;
		seed = 93;
		tb_errors = 0;
		hung = 1'b0;
		repeat (2) @(negedge adc_clkinp);
		rst = 1'b0;
		fd = $fopen("test/capture_testdata.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the test data file");
			tb_errors++;
		end
		while (fd != 0 && !hung && !$feof(fd))
		begin
			tag = "#";
			n = $fgets(line, fd);
			if (n > 0)
				n = $sscanf(line, "%c %h %h %h %h", tag, v0, v1, v2, v3);
			case (tag)
				"c":
				begin
					cfg.rec_length = v0[`ADDR_BITS-1:0];
					cfg.divisor = v1[`DIV_BITS-1:0];
					cfg.mean_mode = v2[0];
					cfg.pack_mode = v3[0];
					trig = 1'b1;
					@(negedge adc_clkinp);
					trig = 1'b0;
					if (!busy)
					begin
						$display("busy did not rise one cycle after the trigger");
						tb_errors++;
					end
					wait_flags(1'b1, 1'b0, "busy after the trigger");
				end
				"w": i_capture_scoreboard.expect_word(v0[`ADDR_BITS-1:0], v1);
				"f": send_frame(v0[FRAME_BITS-1:0]);
				"e": close_record();
				default: ; // comments and blank lines
			endcase
		end
		if (fd != 0)
			$fclose(fd);
		repeat (4) @(negedge adc_clkinp);
		$display("errors: scoreboard %0d, assertions %0d, testbench %0d",
			i_capture_scoreboard.err_cnt, i_adc_capture_top.i_capture_chk.fail_cnt, tb_errors);
		if (i_capture_scoreboard.err_cnt == 0 && i_adc_capture_top.i_capture_chk.fail_cnt == 0
			&& tb_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/capture_testdata.txt
# c rec_length divisor mean_mode pack_mode | w addr word | f frame, lane 7 first | e end of case
# all fields hex, a frame is 12 bits per lane, a word 128 bits
c 2 0 0 0
w 0 00080007000600050004000300020001
w 1 0f080f070f060f050f040f030f020f01
f 008007006005004003002001
f f08f07f06f05f04f03f02f01
e
c 1 3 0 0
w 0 04080407040604050404040304020401
f 111111111111111111111111
f 222222222222222222222222
f 333333333333333333333333
f 408407406405404403402401
e
c 2 2 1 0
w 0 20062005200420032002200120001fff
w 1 00030003000300030003000300030003
f ffffffffffffffffffffffff
f ffffffffffffffffffffffff
f 008007006005004003002001
f 001001001001001001001001
f 001001001001001001001001
f 001001001001001001001001
e
c 3 0 0 1
w 0 0ac09c08c07c06c05c04c03c02c01c00
w 1 5c14c13c12c11c10c0fc0ec0dc0cc0bc
w 2 c1fc1ec1dc1cc1bc1ac19c18c17c16c1
f c07c06c05c04c03c02c01c00
f c0fc0ec0dc0cc0bc0ac09c08
f c17c16c15c14c13c12c11c10
f c1fc1ec1dc1cc1bc1ac19c18
e
c 2 1 0 0
w 0 05a505a505a505a505a505a505a505a5
w 1 07e707e707e707e707e707e707e707e7
f aaaaaaaaaaaaaaaaaaaaaaaa
f 5a55a55a55a55a55a55a55a5
f 111111111111111111111111
f 7e77e77e77e77e77e77e77e7
f 999999999999999999999999
f 888888888888888888888888
e

//--- adc_capture_top.f
+incdir+src
src/adc_sample_pkg.sv
src/capture_ctrl_pkg.sv
src/lane_decimator.sv
src/capture_sequencer.sv
src/word_packer.sv
src/adc_capture_top.sv
test/capture_chk.sv
test/capture_scoreboard.sv
test/capture_tb.sv

//--- Bender.yml
package:
  name: adc_capture

sources:
  - include_dirs:
      - src
    files:
      - src/adc_sample_pkg.sv
      - src/capture_ctrl_pkg.sv
      - src/lane_decimator.sv
      - src/capture_sequencer.sv
      - src/word_packer.sv
      - src/adc_capture_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/capture_chk.sv
      - test/capture_scoreboard.sv
      - test/capture_tb.sv
